/* rtl/periph_bus_pkg.sv */
// Bus-side types and widths shared by the controller and every peripheral slot
package periph_bus_pkg;

    // Core bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 11;

    // Offset inside one full slot of 64 bytes
    localparam int OFS_W = 6;

    // Size code of a core access, all ones means idle
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_e;

    // Request as driven by the core
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        access_size_e      wr_size;
        access_size_e      rd_size;
    } bus_req_t;

    // Request seen by one slot
    // wr_size stays SIZE_NONE unless this slot is addressed by a write
    typedef struct packed {
        logic [OFS_W-1:0]  offset;
        logic [DATA_W-1:0] wdata;
        access_size_e      wr_size;
    } slot_req_t;

    // Response from one slot
    // Slots answer in the same cycle, so there is no ready bit
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } slot_rsp_t;

endpackage

/* rtl/periph_map_pkg.sv */
// Address map, slot numbers, register offsets and reset values of the peripheral space
package periph_map_pkg;

    // Slot counts, the same in full and byte space
    localparam int NUM_SLOTS  = 16;
    localparam int SLOT_IDX_W = 4;

    localparam logic [SLOT_IDX_W-1:0] SLOT_GPIO    = 4'd1;
    localparam logic [SLOT_IDX_W-1:0] SLOT_SCRATCH = 4'd15;

    // Address fields
    localparam int BYTE_SPACE_BIT = 10;
    localparam int FULL_INDEX_LSB = 6;
    localparam int BYTE_INDEX_LSB = 4;

    // GPIO register offsets
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    // Pin n select lives at GPIO_SEL_BASE + 4*n
    localparam logic [5:0] GPIO_SEL_BASE = 6'h20;

    localparam int NUM_PINS = 8;

    // Output function select of one pin
    typedef struct packed {
        logic                  byte_space;
        logic [SLOT_IDX_W-1:0] slot;
    } func_sel_t;

    // All pins start on the GPIO output register
    localparam func_sel_t FUNC_SEL_RESET = '{byte_space: 1'b0, slot: SLOT_GPIO};

endpackage

/* rtl/bus_ctrl.sv */
// Core bus controller: decodes the address, fans requests out to slots and holds read data
`timescale 1ns/1ps

module bus_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  periph_bus_pkg::bus_req_t  i_bus,
    input  logic                      i_data_read_complete,
    input  periph_bus_pkg::slot_rsp_t i_gpio_rsp,
    input  periph_bus_pkg::slot_rsp_t i_full_scratch_rsp,
    input  periph_bus_pkg::slot_rsp_t i_byte_scratch_rsp,
    output periph_bus_pkg::slot_req_t o_gpio_req,
    output periph_bus_pkg::slot_req_t o_full_scratch_req,
    output periph_bus_pkg::slot_req_t o_byte_scratch_req,
    output logic [31:0]               o_data_out,
    output logic                      o_data_ready
);
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    logic                  byte_space;
    logic [SLOT_IDX_W-1:0] full_idx;
    logic [SLOT_IDX_W-1:0] byte_idx;
    logic                  sel_gpio;
    logic                  sel_full_scratch;
    logic                  sel_byte_scratch;
    logic                  wr_req;
    logic                  rd_req;
    logic                  rd_req_peri;
    logic                  rd_ready_peri;
    logic                  capture;
    logic [DATA_W-1:0]     rdata_mux;
    logic [DATA_W-1:0]     data_out_q;
    logic                  hold_q;
    logic                  ready_q;

    function automatic slot_req_t make_req(input logic sel, input logic [OFS_W-1:0] ofs,
                                           input logic [DATA_W-1:0] wdata,
                                           input access_size_e wr_size);
        slot_req_t req;
        req.offset  = ofs;
        req.wdata   = wdata;
        req.wr_size = sel ? wr_size : SIZE_NONE;
        return req;
    endfunction

    assign byte_space = i_bus.addr[BYTE_SPACE_BIT];
    assign full_idx   = i_bus.addr[FULL_INDEX_LSB +: SLOT_IDX_W];
    assign byte_idx   = i_bus.addr[BYTE_INDEX_LSB +: SLOT_IDX_W];

    assign sel_gpio         = !byte_space && (full_idx == SLOT_GPIO);
    assign sel_full_scratch = !byte_space && (full_idx == SLOT_SCRATCH);
    assign sel_byte_scratch = byte_space && (byte_idx == SLOT_SCRATCH);

    assign wr_req = (i_bus.wr_size != SIZE_NONE);
    assign rd_req = (i_bus.rd_size != SIZE_NONE);

    // Every kept slot answers combinationally, empty slots too
    assign rd_ready_peri = 1'b1;
    // No second capture while the registered ready is up
    assign rd_req_peri   = rd_req && !ready_q;
    assign capture       = rd_req_peri && !hold_q && rd_ready_peri;

    assign o_gpio_req = make_req(sel_gpio, i_bus.addr[OFS_W-1:0], i_bus.wdata, i_bus.wr_size);
    assign o_full_scratch_req = make_req(sel_full_scratch, i_bus.addr[OFS_W-1:0],
                                         i_bus.wdata, i_bus.wr_size);
    // Byte slots only see a 16 byte window and the low data byte
    assign o_byte_scratch_req = make_req(sel_byte_scratch,
                                         OFS_W'(i_bus.addr[BYTE_INDEX_LSB-1:0]),
                                         DATA_W'(i_bus.wdata[7:0]), i_bus.wr_size);

    always_comb begin
        rdata_mux = '0;
        if (sel_gpio) begin
            rdata_mux = i_gpio_rsp.rdata;
        end else if (sel_full_scratch) begin
            rdata_mux = i_full_scratch_rsp.rdata;
        end else if (sel_byte_scratch) begin
            rdata_mux = DATA_W'(i_byte_scratch_rsp.rdata[7:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            // Ready drops with the read complete
            ready_q <= rd_req && rd_ready_peri && !i_data_read_complete;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_out_q <= rdata_mux;
        end
    end

    assign o_data_out   = data_out_q;
    assign o_data_ready = ready_q || wr_req;

    // Held read data must not move until the core has taken it
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (o_data_ready && !i_data_read_complete) |=> $stable(o_data_out));

    // A write reaches at most one slot
    a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({o_gpio_req.wr_size != SIZE_NONE, o_full_scratch_req.wr_size != SIZE_NONE,
                  o_byte_scratch_req.wr_size != SIZE_NONE}));

endmodule

/* rtl/gpio_regs.sv */
// GPIO peripheral: output register, input read-back and per-pin output function selects
`timescale 1ns/1ps

module gpio_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  periph_bus_pkg::slot_req_t i_req,
    input  logic [7:0]                i_ui_in,
    output periph_bus_pkg::slot_rsp_t o_rsp,
    output logic [7:0]                o_gpio_out,
    output periph_map_pkg::func_sel_t [periph_map_pkg::NUM_PINS-1:0] o_func_sel
);
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    logic                        wr_en;
    logic [OFS_W-1:0]            sel_ofs;
    logic                        sel_hit;
    logic [$clog2(NUM_PINS)-1:0] sel_idx;
    logic [DATA_W-1:0]           rdata;
    logic [7:0]                  gpio_out_q;
    func_sel_t [NUM_PINS-1:0]    func_sel_q;

    assign wr_en = (i_req.wr_size != SIZE_NONE);

    // Select window is word aligned from GPIO_SEL_BASE to the end of the slot
    assign sel_ofs = i_req.offset - GPIO_SEL_BASE;
    assign sel_hit = (i_req.offset >= GPIO_SEL_BASE) && (sel_ofs[1:0] == 2'b00);
    assign sel_idx = sel_ofs[2 +: $clog2(NUM_PINS)];

    // Any write size updates the register, only the low bits are kept
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
        end else if (wr_en && (i_req.offset == GPIO_OUT_OFS)) begin
            gpio_out_q <= i_req.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            func_sel_q <= {NUM_PINS{FUNC_SEL_RESET}};
        end else if (wr_en && sel_hit) begin
            func_sel_q[sel_idx] <= func_sel_t'(i_req.wdata[$bits(func_sel_t)-1:0]);
        end
    end

    always_comb begin
        rdata = '0;
        if (i_req.offset == GPIO_OUT_OFS) begin
            rdata = DATA_W'(gpio_out_q);
        end else if (i_req.offset == GPIO_IN_OFS) begin
            rdata = DATA_W'(i_ui_in);
        end else if (sel_hit) begin
            rdata = DATA_W'(func_sel_q[sel_idx]);
        end
    end

    assign o_rsp.rdata = rdata;
    assign o_gpio_out  = gpio_out_q;
    assign o_func_sel  = func_sel_q;

endmodule

/* rtl/pin_out_mux.sv */
// Output pin mux: each pin takes its bit from the slot named by its function select
`timescale 1ns/1ps

module pin_out_mux (
    input  periph_map_pkg::func_sel_t [periph_map_pkg::NUM_PINS-1:0] i_func_sel,
    input  logic [7:0] i_gpio_out,
    input  logic [7:0] i_full_scratch_byte,
    input  logic [7:0] i_byte_scratch_byte,
    output logic [7:0] o_uo_out
);
    import periph_map_pkg::*;

    logic [NUM_SLOTS-1:0][7:0] full_bytes;
    logic [NUM_SLOTS-1:0][7:0] byte_bytes;

    // Slots without a peripheral drive zero
    always_comb begin
        full_bytes               = '0;
        byte_bytes               = '0;
        full_bytes[SLOT_GPIO]    = i_gpio_out;
        full_bytes[SLOT_SCRATCH] = i_full_scratch_byte;
        byte_bytes[SLOT_SCRATCH] = i_byte_scratch_byte;
    end

    // Pin n always takes bit n of the owning slot's byte
    always_comb begin
        o_uo_out = '0;
        for (int n = 0; n < NUM_PINS; n++) begin
            if (i_func_sel[n].byte_space) begin
                o_uo_out[n] = byte_bytes[i_func_sel[n].slot][n];
            end else begin
                o_uo_out[n] = full_bytes[i_func_sel[n].slot][n];
            end
        end
    end

endmodule

/* rtl/scratch_regs.sv */
// Scratch peripheral: four read/write registers of a configurable word type
`timescale 1ns/1ps

module scratch_regs #(
    parameter type word_t = logic [31:0]
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  periph_bus_pkg::slot_req_t i_req,
    output periph_bus_pkg::slot_rsp_t o_rsp,
    output logic [7:0]                o_pin_byte
);
    import periph_bus_pkg::*;

    logic              wr_en;
    logic [OFS_W-1:0]  word_ofs;
    logic [1:0]        idx;
    logic [DATA_W-1:0] wmask;
    word_t             wmask_w;
    word_t             wdata_w;
    word_t [3:0]       regs_q;

    assign wr_en = (i_req.wr_size != SIZE_NONE);

    // Registers sit one word apart, so 32-bit words use offset bits 3:2
    assign word_ofs = i_req.offset >> $clog2($bits(word_t) / 8);
    assign idx      = word_ofs[1:0];

    always_comb begin
        case (i_req.wr_size)
            SIZE_BYTE: wmask = DATA_W'(8'hff);
            SIZE_HALF: wmask = DATA_W'(16'hffff);
            SIZE_WORD: wmask = '1;
            default:   wmask = '0;
        endcase
    end

    // Narrow words keep only the bits they can hold
    assign wmask_w = word_t'(wmask);
    assign wdata_w = word_t'(i_req.wdata);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs_q <= '0;
        end else if (wr_en) begin
            regs_q[idx] <= (regs_q[idx] & ~wmask_w) | (wdata_w & wmask_w);
        end
    end

    assign o_rsp.rdata = DATA_W'(regs_q[idx]);
    // Register 0 also drives the pins
    assign o_pin_byte  = 8'(regs_q[0]);

endmodule

/* rtl/periph_top.sv */
// Peripheral wrapper top: connects the bus controller, GPIO, scratch slots and pin mux
`timescale 1ns/1ps

module periph_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  periph_bus_pkg::bus_req_t i_bus,
    input  logic                     i_data_read_complete,
    input  logic [7:0]               i_ui_in,
    output logic [31:0]              o_data_out,
    output logic                     o_data_ready,
    output logic [7:0]               o_uo_out
);
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    slot_req_t                gpio_req;
    slot_req_t                full_scratch_req;
    slot_req_t                byte_scratch_req;
    slot_rsp_t                gpio_rsp;
    slot_rsp_t                full_scratch_rsp;
    slot_rsp_t                byte_scratch_rsp;
    func_sel_t [NUM_PINS-1:0] func_sel;
    logic [7:0]               gpio_out;
    logic [7:0]               full_scratch_byte;
    logic [7:0]               byte_scratch_byte;

    bus_ctrl u_bus_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_bus                (i_bus),
        .i_data_read_complete (i_data_read_complete),
        .i_gpio_rsp           (gpio_rsp),
        .i_full_scratch_rsp   (full_scratch_rsp),
        .i_byte_scratch_rsp   (byte_scratch_rsp),
        .o_gpio_req           (gpio_req),
        .o_full_scratch_req   (full_scratch_req),
        .o_byte_scratch_req   (byte_scratch_req),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    // Full slot 1
    gpio_regs u_gpio_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (gpio_req),
        .i_ui_in    (i_ui_in),
        .o_rsp      (gpio_rsp),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    // Full slot 15
    scratch_regs #(.word_t(logic [DATA_W-1:0])) u_full_scratch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (full_scratch_req),
        .o_rsp      (full_scratch_rsp),
        .o_pin_byte (full_scratch_byte)
    );

    // Byte slot 15
    scratch_regs #(.word_t(logic [7:0])) u_byte_scratch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (byte_scratch_req),
        .o_rsp      (byte_scratch_rsp),
        .o_pin_byte (byte_scratch_byte)
    );

    pin_out_mux u_pin_out_mux (
        .i_func_sel          (func_sel),
        .i_gpio_out          (gpio_out),
        .i_full_scratch_byte (full_scratch_byte),
        .i_byte_scratch_byte (byte_scratch_byte),
        .o_uo_out            (o_uo_out)
    );

endmodule

/* verif/tb_periph_top.sv */
// Testbench for periph_top: runs bus writes and reads against a register model of the slots
`timescale 1ns/1ps

module tb_periph_top;
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    localparam int READ_TIMEOUT = 20;

    logic        clk;
    logic        rst_n;
    bus_req_t    bus;
    logic        data_read_complete;
    logic [7:0]  ui_in;
    logic [31:0] data_out;
    logic        data_ready;
    logic [7:0]  uo_out;
    logic        rd_active;
    integer      seed;

    // Register model of GPIO and both scratch slots
    logic [7:0]               gpio_m;
    func_sel_t [NUM_PINS-1:0] sel_m;
    logic [3:0][31:0]         full_m;
    logic [3:0][7:0]          byte_m;

    periph_top UUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_bus                (bus),
        .i_data_read_complete (data_read_complete),
        .i_ui_in              (ui_in),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .o_uo_out             (uo_out)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            abort_run();
        end
    endtask

    assign rd_active = (bus.rd_size != SIZE_NONE);

    // Bus handshake rules
    write_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.wr_size != SIZE_NONE) |-> data_ready)
        else report_error("o_data_ready was low in a write cycle");
    read_first: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rd_active) |-> !data_ready)
        else report_error("o_data_ready was high in the read request cycle");
    read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rd_active) |=> data_ready)
        else report_error("o_data_ready did not rise one cycle after the read request");
    read_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (data_ready && rd_active && !data_read_complete) |=> $stable(data_out))
        else report_error("o_data_out changed before the read was complete");
    idle_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (!rd_active && bus.wr_size == SIZE_NONE) |-> !data_ready)
        else report_error("o_data_ready was high on an idle bus");

    function automatic logic [ADDR_W-1:0] full_addr(input logic [3:0] slot,
                                                   input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic logic [ADDR_W-1:0] byte_addr(input logic [3:0] slot,
                                                   input logic [3:0] ofs);
        return {1'b1, 2'b00, slot, ofs};
    endfunction

    // Byte, halfword or word lane update of a 32-bit register
    function automatic logic [31:0] merge_write(input logic [31:0] old, input logic [31:0] data,
                                                input access_size_e size);
        case (size)
            SIZE_BYTE: return {old[31:8], data[7:0]};
            SIZE_HALF: return {old[31:16], data[15:0]};
            SIZE_WORD: return data;
            default:   return old;
        endcase
    endfunction

    // Pin n shows bit n of the byte owned by its selected slot
    function automatic logic [7:0] expected_pins();
        logic [7:0] pins;
        logic [7:0] src;
        pins = '0;
        for (int n = 0; n < NUM_PINS; n++) begin
            src = 8'h00;
            if (sel_m[n].byte_space) begin
                if (sel_m[n].slot == SLOT_SCRATCH) src = byte_m[0];
            end else if (sel_m[n].slot == SLOT_GPIO) begin
                src = gpio_m;
            end else if (sel_m[n].slot == SLOT_SCRATCH) begin
                src = full_m[0][7:0];
            end
            pins[n] = src[n];
        end
        return pins;
    endfunction

    task automatic check_pins();
        @(negedge clk);
        check_value("o_uo_out", 32'(uo_out), 32'(expected_pins()));
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                             input access_size_e size);
        @(posedge clk);
        bus.addr    <= addr;
        bus.wdata   <= data;
        bus.wr_size <= size;
        @(posedge clk);
        bus.wr_size <= SIZE_NONE;
    endtask

    task automatic bus_read_check(input logic [ADDR_W-1:0] addr, input logic [31:0] exp);
        int          cycles;
        int          hold_cycles;
        logic [31:0] got;
        hold_cycles = $unsigned($random(seed)) % 6;
        @(posedge clk);
        bus.addr    <= addr;
        bus.rd_size <= SIZE_WORD;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!data_ready && cycles < READ_TIMEOUT);
        assert (data_ready) else report_error("timeout waiting for o_data_ready on a read");
        got = data_out;
        check_value("o_data_out", got, exp);
        // Core stalls before it takes the data
        repeat (hold_cycles) begin
            @(negedge clk);
            check_value("o_data_out", data_out, exp);
        end
        @(posedge clk);
        data_read_complete <= 1'b1;
        @(posedge clk);
        data_read_complete <= 1'b0;
        bus.rd_size        <= SIZE_NONE;
    endtask

    task automatic write_sel(input int pin, input func_sel_t sel);
        logic [ADDR_W-1:0] addr;
        addr = full_addr(SLOT_GPIO, GPIO_SEL_BASE + 6'(4 * pin));
        bus_write(addr, 32'(sel), SIZE_WORD);
        sel_m[pin] = sel;
        bus_read_check(addr, 32'(sel));
        check_pins();
    endtask

    initial begin
        logic [31:0]  data;
        logic [7:0]   in_byte;
        func_sel_t    sel;
        access_size_e sizes [3];
        seed               = 32'h5d43;
        sizes              = '{SIZE_WORD, SIZE_BYTE, SIZE_HALF};
        rst_n              = 1'b0;
        bus                = '{addr: '0, wdata: '0, wr_size: SIZE_NONE, rd_size: SIZE_NONE};
        data_read_complete = 1'b0;
        ui_in              = 8'h00;
        gpio_m             = 8'h00;
        sel_m              = {NUM_PINS{FUNC_SEL_RESET}};
        full_m             = '0;
        byte_m             = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Idle after reset, all pins on the cleared GPIO register
        repeat (3) begin
            @(negedge clk);
            check_value("o_data_ready", 32'(data_ready), 32'd0);
        end
        check_value("o_uo_out", 32'(uo_out), 32'd0);

        repeat (4) begin
            data = $random(seed);
            bus_write(full_addr(SLOT_GPIO, GPIO_OUT_OFS), data, SIZE_WORD);
            gpio_m = data[7:0];
            bus_read_check(full_addr(SLOT_GPIO, GPIO_OUT_OFS), 32'(gpio_m));
            check_pins();
            in_byte = 8'($random(seed));
            @(posedge clk);
            ui_in <= in_byte;
            bus_read_check(full_addr(SLOT_GPIO, GPIO_IN_OFS), 32'(in_byte));
        end

        // Move the pins one by one onto full scratch register 0
        sel = '{byte_space: 1'b0, slot: SLOT_SCRATCH};
        for (int n = 0; n < NUM_PINS; n++) begin
            write_sel(n, sel);
            data = $random(seed);
            bus_write(full_addr(SLOT_SCRATCH, 6'h00), data, SIZE_WORD);
            full_m[0] = data;
            check_pins();
        end

        // Byte scratch on the low pins, empty slots on the rest
        for (int n = 0; n < NUM_PINS; n++) begin
            if (n < 4) sel = '{byte_space: 1'b1, slot: SLOT_SCRATCH};
            else if (n < 6) sel = '{byte_space: 1'b0, slot: 4'd3};
            else sel = '{byte_space: 1'b1, slot: 4'd2};
            write_sel(n, sel);
        end
        bus_write(byte_addr(SLOT_SCRATCH, 4'h0), 32'h0000_00ff, SIZE_BYTE);
        byte_m[0] = 8'hff;
        check_pins();
        for (int n = 0; n < NUM_PINS; n++) begin
            write_sel(n, FUNC_SEL_RESET);
        end

        for (int k = 0; k < 4; k++) begin
            for (int s = 0; s < 3; s++) begin
                data = $random(seed);
                bus_write(full_addr(SLOT_SCRATCH, 6'(4 * k)), data, sizes[s]);
                full_m[k] = merge_write(full_m[k], data, sizes[s]);
                bus_read_check(full_addr(SLOT_SCRATCH, 6'(4 * k)), full_m[k]);
            end
        end

        for (int k = 0; k < 4; k++) begin
            data = $random(seed);
            bus_write(byte_addr(SLOT_SCRATCH, 4'(k)), data, sizes[k % 3]);
            byte_m[k] = data[7:0];
        end
        for (int k = 0; k < 4; k++) begin
            bus_read_check(byte_addr(SLOT_SCRATCH, 4'(k)), 32'(byte_m[k]));
        end
        bus_read_check(full_addr(4'd3, 6'h00), 32'd0);
        bus_read_check(byte_addr(4'd2, 4'h0), 32'd0);
        bus_read_check(byte_addr(SLOT_GPIO, 4'h0), 32'd0);
        check_pins();

        repeat (2) @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

/* project.f */
rtl/periph_bus_pkg.sv
rtl/periph_map_pkg.sv
rtl/bus_ctrl.sv
rtl/gpio_regs.sv
rtl/pin_out_mux.sv
rtl/scratch_regs.sv
rtl/periph_top.sv
verif/tb_periph_top.sv

/* Makefile */
TOP := tb_periph_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "test failed" sim.log; then echo "simulation reported an error"; exit 1; fi
	@grep -q "test passed" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
